/* riscv_pkg.sv */
// riscv front end shared definitions
// opcode constants, decoded function codes and immediate formats
`default_nettype none

package riscv_pkg;

  // widest data path, sizes the immediate
  localparam int XLEN_MAX = 64;
  localparam int FUNC_W = 6;
  localparam int IMM_FMT_W = 3;

  ////////////////////////////////////////
  // major opcodes, instr[6:0]
  ////////////////////////////////////////
  localparam logic [6:0] OP_LOAD     = 7'b0000011;
  localparam logic [6:0] OP_STORE    = 7'b0100011;
  localparam logic [6:0] OP_BRANCH   = 7'b1100011;
  localparam logic [6:0] OP_JAL      = 7'b1101111;
  localparam logic [6:0] OP_JALR     = 7'b1100111;
  localparam logic [6:0] OP_LUI      = 7'b0110111;
  localparam logic [6:0] OP_AUIPC    = 7'b0010111;
  localparam logic [6:0] OP_IMM      = 7'b0010011;
  localparam logic [6:0] OP_OP       = 7'b0110011;
  // rv64 word forms
  localparam logic [6:0] OP_IMM32    = 7'b0011011;
  localparam logic [6:0] OP_OP32     = 7'b0111011;
  localparam logic [6:0] OP_MISC_MEM = 7'b0001111;
  localparam logic [6:0] OP_SYSTEM   = 7'b1110011;

  ////////////////////////////////////////
  // decoded operations
  ////////////////////////////////////////
  // numbering is fixed, trace data depends on it
  typedef enum logic [FUNC_W-1:0] {
    ILLEGAL = 6'd0,
    // loads, 0x01..0x07
    LB, LH, LW, LD, LBU, LHU, LWU,
    // stores, 0x08..0x0b
    SB, SH, SW, SD,
    // branches, 0x0c..0x11
    BEQ, BNE, BLT, BGE, BLTU, BGEU,
    // jumps and upper immediates, 0x12..0x15
    JAL, JALR, LUI, AUIPC,
    // op-imm, 0x16..0x1e
    ADDI, SLTI, SLTIU, XORI, ORI, ANDI, SLLI, SRLI, SRAI,
    // op, 0x1f..0x28
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
    // rv64 word forms, 0x29..0x31
    ADDIW, SLLIW, SRLIW, SRAIW, ADDW, SUBW, SLLW, SRLW, SRAW,
    // system and ordering, 0x32..0x34
    FENCE, ECALL, EBREAK
  } func_t;

  // immediate layout selector
  typedef enum logic [IMM_FMT_W-1:0] {
    NONE = 3'd0,
    I    = 3'd1,
    S    = 3'd2,
    B    = 3'd3,
    U    = 3'd4,
    J    = 3'd5
  } imm_fmt_t;

endpackage

`default_nettype wire

/* rv_if.sv */
// instruction fetch unit
// wishbone classic read master stepping the pc by one word
// one fetch in flight, the word is held with valid until taken
`timescale 1ns/10ps
`default_nettype none

module rv_if (
  input  logic        clk_i,
  input  logic        rst_i,
  // wishbone classic master
  output logic        wb_cyc_o,
  output logic        wb_stb_o,
  output logic [31:0] wb_adr_o,
  output logic        wb_we_o,
  input  logic [31:0] wb_dat_i,
  input  logic        wb_ack_i,
  // towards decode
  output logic [31:0] instr_o,
  output logic [31:0] pc_o,
  output logic        valid_o,
  input  logic        ready_i
);

  typedef enum logic {
    FETCH = 1'b0,
    HOLD  = 1'b1
  } if_state_e;

  if_state_e   state_q;
  logic        cyc_q;
  logic [31:0] pc_q;
  logic [31:0] instr_q;

  ////////////////////////////////////////
  // fetch / hold fsm
  ////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= FETCH;
      cyc_q   <= 1'b0;
      pc_q    <= '0;
    end else begin
      case (state_q)
        FETCH: begin
          // idle only in the first cycle out of reset
          if (!cyc_q) begin
            cyc_q <= 1'b1;
          end else if (wb_ack_i) begin
            cyc_q   <= 1'b0;
            state_q <= HOLD;
          end
        end
        HOLD: begin
          // accepted, step pc and fetch again right away
          if (ready_i) begin
            pc_q    <= pc_q + 32'd4;
            cyc_q   <= 1'b1;
            state_q <= FETCH;
          end
        end
      endcase
    end
  end

  // holding register, loaded on the ack edge
  always_ff @(posedge clk_i) begin
    if (state_q == FETCH && cyc_q && wb_ack_i) begin
      instr_q <= wb_dat_i;
    end
  end

  // bus side, read only
  assign wb_cyc_o = cyc_q;
  assign wb_stb_o = cyc_q;
  assign wb_adr_o = pc_q;
  assign wb_we_o  = 1'b0;

  // decode side
  assign instr_o = instr_q;
  assign pc_o    = pc_q;
  assign valid_o = (state_q == HOLD);

  ////////////////////////////////////////
  // protocol checks
  ////////////////////////////////////////
  // address and cycle held until the slave answers
  bus_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
    wb_cyc_o && !wb_ack_i |=> wb_cyc_o && $stable(wb_adr_o))
    else $error("bus cycle dropped or address moved before ack");

  // stalled word and its pc must not move
  hold_stable_a: assert property (@(posedge clk_i) disable iff (rst_i)
    valid_o && !ready_i |=> $stable(instr_o) && $stable(pc_o))
    else $error("held instruction changed under back-pressure");

  no_fetch_while_held_a: assert property (@(posedge clk_i) disable iff (rst_i)
    !(wb_cyc_o && valid_o))
    else $error("bus cycle open while an instruction is held");

endmodule

`default_nettype wire

/* rv_imm_gen.sv */
// immediate generator
// collects the scattered immediate bits of the I, S, B, U and J layouts
// and sign-extends them from instr[31] to the full immediate width
`timescale 1ns/10ps
`default_nettype none

module rv_imm_gen #(
  parameter bit RV64I = 1'b0
) (
  input  logic [31:0]                    instr_i,
  input  riscv_pkg::imm_fmt_t            imm_fmt_i,
  output logic [riscv_pkg::XLEN_MAX-1:0] imm_o
);

  import riscv_pkg::*;

  // register width of the configured core
  localparam int XLEN = RV64I ? 64 : 32;

  logic            sign;
  logic [31:0]     imm32;
  logic [XLEN-1:0] imm_native;

  // every format takes its sign from bit 31
  assign sign = instr_i[31];

  always_comb begin
    case (imm_fmt_i)
      I: imm32 = {{20{sign}}, instr_i[31:20]};
      S: imm32 = {{20{sign}}, instr_i[31:25], instr_i[11:7]};
      // branch offset, bit 0 always zero
      B: imm32 = {{20{sign}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
      // upper 20 bits, low 12 cleared
      U: imm32 = {instr_i[31:12], 12'b0};
      // jump offset, bit 0 always zero
      J: imm32 = {{12{sign}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
      default: imm32 = '0;
    endcase
  end

  // widen to the core width, then to the port width
  assign imm_native = XLEN'($signed(imm32));
  assign imm_o      = XLEN_MAX'($signed(imm_native));

endmodule

`default_nettype wire

/* rv_id.sv */
// instruction decoder
// maps opcode, funct3 and funct7 onto a function code, picks the
// immediate layout and passes on the register fields that it uses
// rv64 encodings only decode with RV64I set, the rest is ILLEGAL
`timescale 1ns/10ps
`default_nettype none

module rv_id #(
  parameter bit RV64I = 1'b0
) (
  input  logic [31:0]         instr_i,
  output riscv_pkg::func_t    func_o,
  output logic [4:0]          rd_o,
  output logic [4:0]          rs1_o,
  output logic [4:0]          rs2_o,
  output riscv_pkg::imm_fmt_t imm_fmt_o
);

  import riscv_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [5:0] funct6;
  logic       shamt_ok;
  func_t      func;
  imm_fmt_t   fmt;
  logic       use_rd;
  logic       use_rs1;
  logic       use_rs2;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  assign funct6 = instr_i[31:26];
  // shamt[5] only exists on rv64
  assign shamt_ok = !instr_i[25] || RV64I;

  ////////////////////////////////////////
  // opcode and funct fields to func
  ////////////////////////////////////////
  always_comb begin
    func = ILLEGAL;
    case (opcode)
      OP_LOAD: begin
        case (funct3)
          3'b000: func = LB;
          3'b001: func = LH;
          3'b010: func = LW;
          3'b011: if (RV64I) func = LD;
          3'b100: func = LBU;
          3'b101: func = LHU;
          3'b110: if (RV64I) func = LWU;
          default: func = ILLEGAL;
        endcase
      end
      OP_STORE: begin
        case (funct3)
          3'b000: func = SB;
          3'b001: func = SH;
          3'b010: func = SW;
          3'b011: if (RV64I) func = SD;
          default: func = ILLEGAL;
        endcase
      end
      OP_BRANCH: begin
        case (funct3)
          3'b000: func = BEQ;
          3'b001: func = BNE;
          3'b100: func = BLT;
          3'b101: func = BGE;
          3'b110: func = BLTU;
          3'b111: func = BGEU;
          default: func = ILLEGAL;
        endcase
      end
      OP_JAL: func = JAL;
      OP_JALR: if (funct3 == 3'b000) func = JALR;
      OP_LUI: func = LUI;
      OP_AUIPC: func = AUIPC;
      OP_IMM: begin
        case (funct3)
          3'b000: func = ADDI;
          3'b010: func = SLTI;
          3'b011: func = SLTIU;
          3'b100: func = XORI;
          3'b110: func = ORI;
          3'b111: func = ANDI;
          3'b001: if (funct6 == 6'b000000 && shamt_ok) func = SLLI;
          // bit 30 splits logical and arithmetic shift
          default: begin
            if (funct6 == 6'b000000 && shamt_ok) func = SRLI;
            else if (funct6 == 6'b010000 && shamt_ok) func = SRAI;
          end
        endcase
      end
      OP_OP: begin
        if (funct7 == 7'b0000000) begin
          case (funct3)
            3'b000: func = ADD;
            3'b001: func = SLL;
            3'b010: func = SLT;
            3'b011: func = SLTU;
            3'b100: func = XOR;
            3'b101: func = SRL;
            3'b110: func = OR;
            default: func = AND;
          endcase
        end else if (funct7 == 7'b0100000) begin
          if (funct3 == 3'b000) func = SUB;
          else if (funct3 == 3'b101) func = SRA;
        end
      end
      OP_IMM32: begin
        if (RV64I) begin
          if (funct3 == 3'b000) func = ADDIW;
          else if (funct3 == 3'b001 && funct7 == 7'b0000000) func = SLLIW;
          else if (funct3 == 3'b101 && funct7 == 7'b0000000) func = SRLIW;
          else if (funct3 == 3'b101 && funct7 == 7'b0100000) func = SRAIW;
        end
      end
      OP_OP32: begin
        if (RV64I && funct7 == 7'b0000000) begin
          if (funct3 == 3'b000) func = ADDW;
          else if (funct3 == 3'b001) func = SLLW;
          else if (funct3 == 3'b101) func = SRLW;
        end else if (RV64I && funct7 == 7'b0100000) begin
          if (funct3 == 3'b000) func = SUBW;
          else if (funct3 == 3'b101) func = SRAW;
        end
      end
      // fence.i and friends stay illegal
      OP_MISC_MEM: if (funct3 == 3'b000) func = FENCE;
      OP_SYSTEM: begin
        // rd, funct3 and rs1 all zero, csr forms fall out here
        if (instr_i[19:7] == 13'b0) begin
          if (instr_i[31:20] == 12'h000) func = ECALL;
          else if (instr_i[31:20] == 12'h001) func = EBREAK;
        end
      end
      default: func = ILLEGAL;
    endcase
  end

  ////////////////////////////////////////
  // func to format and used fields
  ////////////////////////////////////////
  always_comb begin
    fmt     = NONE;
    use_rd  = 1'b0;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    case (func) inside
      // fence carries pred/succ in the I slot
      [LB:LWU], [ADDI:SRAI], [ADDIW:SRAIW], JALR, FENCE: begin
        fmt     = I;
        use_rd  = 1'b1;
        use_rs1 = 1'b1;
      end
      [SB:SD]: begin
        fmt     = S;
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
      end
      [BEQ:BGEU]: begin
        fmt     = B;
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
      end
      JAL: begin
        fmt    = J;
        use_rd = 1'b1;
      end
      LUI, AUIPC: begin
        fmt    = U;
        use_rd = 1'b1;
      end
      // register-register, no immediate
      [ADD:AND], [ADDW:SRAW]: begin
        use_rd  = 1'b1;
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
      end
      default: fmt = NONE;
    endcase
  end

  assign func_o    = func;
  assign imm_fmt_o = fmt;
  assign rd_o      = use_rd ? instr_i[11:7] : 5'd0;
  assign rs1_o     = use_rs1 ? instr_i[19:15] : 5'd0;
  assign rs2_o     = use_rs2 ? instr_i[24:20] : 5'd0;

endmodule

`default_nettype wire

/* rv_frontend.sv */
// riscv front end top
// fetch over wishbone, decode and immediate generation, handed on
// through a valid/ready pair
`timescale 1ns/10ps
`default_nettype none

module rv_frontend #(
  parameter bit RV64I = 1'b0
) (
  input  logic                           clk_i,
  input  logic                           rst_i,
  // wishbone classic master
  output logic                           wb_cyc_o,
  output logic                           wb_stb_o,
  output logic [31:0]                    wb_adr_o,
  output logic                           wb_we_o,
  input  logic [31:0]                    wb_dat_i,
  input  logic                           wb_ack_i,
  // decoded instruction to the next stage
  output logic                           dec_valid_o,
  input  logic                           dec_ready_i,
  output logic [31:0]                    dec_pc_o,
  output riscv_pkg::func_t               dec_func_o,
  output logic [4:0]                     dec_rd_o,
  output logic [4:0]                     dec_rs1_o,
  output logic [4:0]                     dec_rs2_o,
  output logic [riscv_pkg::XLEN_MAX-1:0] dec_imm_o
);

  import riscv_pkg::*;

  // held instruction word and its layout
  logic [31:0] instr;
  imm_fmt_t    imm_fmt;

  rv_if u_if (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .wb_cyc_o(wb_cyc_o),
    .wb_stb_o(wb_stb_o),
    .wb_adr_o(wb_adr_o),
    .wb_we_o (wb_we_o),
    .wb_dat_i(wb_dat_i),
    .wb_ack_i(wb_ack_i),
    .instr_o (instr),
    .pc_o    (dec_pc_o),
    .valid_o (dec_valid_o),
    .ready_i (dec_ready_i)
  );

  // decode is combinational on the held word
  rv_id #(
    .RV64I(RV64I)
  ) u_id (
    .instr_i  (instr),
    .func_o   (dec_func_o),
    .rd_o     (dec_rd_o),
    .rs1_o    (dec_rs1_o),
    .rs2_o    (dec_rs2_o),
    .imm_fmt_o(imm_fmt)
  );

  rv_imm_gen #(
    .RV64I(RV64I)
  ) u_imm_gen (
    .instr_i  (instr),
    .imm_fmt_i(imm_fmt),
    .imm_o    (dec_imm_o)
  );

endmodule

`default_nettype wire

/* rv_frontend_tb_mem.sv */
// testbench wishbone slave
// read-only word memory, loaded by the testbench top from the trace,
// answers each request after 0 to 3 wait states picked by wait_i
`timescale 1ns/10ps
`default_nettype none

module rv_frontend_tb_mem #(
  parameter int DEPTH = 64
) (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic [31:0] wb_adr_i,
  input  logic [1:0]  wait_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack_o
);

  logic [31:0] mem [DEPTH];
  logic        busy_q;
  logic [1:0]  cnt_q;

  // words past the end read as zero
  function automatic logic [31:0] read_word(input logic [31:0] adr);
    if (adr[31:2] < DEPTH) begin
      return mem[adr[31:2]];
    end
    return 32'h0;
  endfunction

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wb_ack_o <= 1'b0;
      wb_dat_o <= '0;
      busy_q   <= 1'b0;
      cnt_q    <= '0;
    end else begin
      // ack is a single cycle pulse
      wb_ack_o <= 1'b0;
      if (wb_cyc_i && wb_stb_i && !wb_ack_o) begin
        if (!busy_q) begin
          // new request, wait count latched here
          if (wait_i == 2'd0) begin
            wb_ack_o <= 1'b1;
            wb_dat_o <= read_word(wb_adr_i);
          end else begin
            busy_q <= 1'b1;
            cnt_q  <= wait_i;
          end
        end else if (cnt_q == 2'd1) begin
          wb_ack_o <= 1'b1;
          wb_dat_o <= read_word(wb_adr_i);
          busy_q   <= 1'b0;
        end else begin
          cnt_q <= cnt_q - 2'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* rv_frontend_tb.sv */
// front end testbench
// feeds the trace through a wishbone memory with random wait states,
// applies random back-pressure and checks every decoded transfer
`timescale 1ns/10ps
`default_nettype none

module rv_frontend_tb;

  import riscv_pkg::*;

  localparam int DEPTH = 64;
  localparam logic [31:0] LFSR_SEED = 32'hb184_e48d;

  logic        clk_i;
  logic        rst_i;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic        wb_ack;
  logic [31:0] wb_adr;
  logic [31:0] wb_dat;
  logic [1:0]  wait_bits;
  logic        dec_valid;
  logic        dec_ready;
  logic [31:0] dec_pc;
  func_t       dec_func;
  logic [4:0]  dec_rd;
  logic [4:0]  dec_rs1;
  logic [4:0]  dec_rs2;
  logic [63:0] dec_imm;

  // expected values, one slot per trace line
  logic [31:0] exp_instr [DEPTH];
  logic [5:0]  exp_func [DEPTH];
  logic [4:0]  exp_rd [DEPTH];
  logic [4:0]  exp_rs1 [DEPTH];
  logic [4:0]  exp_rs2 [DEPTH];
  logic [63:0] exp_imm [DEPTH];

  int          n_entries;
  int          n_lines;
  int          limit;
  int          cycles;
  int          n_xfer;
  int          val_errs;
  int          proto_errs;
  int          other_errs;
  logic [31:0] lfsr;
  bit          first_chk;
  bit          done;

  // previous cycle, for stability checks
  logic        prev_valid;
  logic        prev_ready;
  logic        prev_cyc;
  logic        prev_ack;
  logic [31:0] prev_adr;
  logic [31:0] prev_pc;
  logic [5:0]  prev_func;
  logic [4:0]  prev_rd;
  logic [4:0]  prev_rs1;
  logic [4:0]  prev_rs2;
  logic [63:0] prev_imm;

  rv_frontend #(
    .RV64I(1'b1)
  ) DUT (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .wb_cyc_o   (wb_cyc),
    .wb_stb_o   (wb_stb),
    .wb_adr_o   (wb_adr),
    .wb_we_o    (wb_we),
    .wb_dat_i   (wb_dat),
    .wb_ack_i   (wb_ack),
    .dec_valid_o(dec_valid),
    .dec_ready_i(dec_ready),
    .dec_pc_o   (dec_pc),
    .dec_func_o (dec_func),
    .dec_rd_o   (dec_rd),
    .dec_rs1_o  (dec_rs1),
    .dec_rs2_o  (dec_rs2),
    .dec_imm_o  (dec_imm)
  );

  rv_frontend_tb_mem #(
    .DEPTH(DEPTH)
  ) u_mem (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .wb_cyc_i(wb_cyc),
    .wb_stb_i(wb_stb),
    .wb_adr_i(wb_adr),
    .wait_i  (wait_bits),
    .wb_dat_o(wb_dat),
    .wb_ack_o(wb_ack)
  );

  // fibonacci lfsr, taps 32 22 2 1, new bit enters at bit 0
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic check_val(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
    if (got !== exp) begin
      val_errs++;
      $display("FAIL %s got %h expected %h (transfer %0d)", name, got, exp, n_xfer);
    end
  endtask

  task automatic end_run();
    $display("errors: value %0d, protocol %0d, other %0d", val_errs, proto_errs,
             other_errs);
    if (val_errs + proto_errs + other_errs == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  ////////////////////////////////////////
  // trace loading
  ////////////////////////////////////////
  task automatic load_trace();
    int          fd;
    int          code;
    string       line;
    logic [31:0] w;
    logic [31:0] f;
    logic [31:0] d;
    logic [31:0] s1;
    logic [31:0] s2;
    logic [63:0] im;
    fd = $fopen("rv_frontend_trace.txt", "r");
    if (fd == 0) begin
      other_errs++;
      $display("could not open the trace file");
      return;
    end
    while (!$feof(fd) && n_lines < DEPTH) begin
      code = $fgets(line, fd);
      // skip blank and comment lines
      if (code == 0 || line.len() < 8 || line.substr(0, 1) == "//") begin
        continue;
      end
      code = $sscanf(line, "%h %h %h %h %h %h", w, f, d, s1, s2, im);
      if (code != 6) begin
        other_errs++;
        $display("malformed trace line: %s", line);
        continue;
      end
      n_lines++;
      // all-zero line ends the trace
      if (w == 0 && f == 0 && d == 0 && s1 == 0 && s2 == 0 && im == 0) begin
        break;
      end
      exp_instr[n_entries] = w;
      exp_func[n_entries]  = f[5:0];
      exp_rd[n_entries]    = d[4:0];
      exp_rs1[n_entries]   = s1[4:0];
      exp_rs2[n_entries]   = s2[4:0];
      exp_imm[n_entries]   = im;
      n_entries++;
    end
    $fclose(fd);
    for (int i = 0; i < DEPTH; i++) begin
      u_mem.mem[i] = (i < n_entries) ? exp_instr[i] : 32'h0;
    end
  endtask

  // clock, 4 ns period
  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  initial begin
    rst_i      = 1'b1;
    dec_ready  = 1'b0;
    wait_bits  = 2'd0;
    lfsr       = LFSR_SEED;
    n_entries  = 0;
    n_lines    = 0;
    cycles     = 0;
    n_xfer     = 0;
    val_errs   = 0;
    proto_errs = 0;
    other_errs = 0;
    first_chk  = 1'b1;
    done       = 1'b0;
    prev_valid = 1'b0;
    prev_ready = 1'b0;
    prev_cyc   = 1'b0;
    prev_ack   = 1'b0;
    load_trace();
    if (n_entries == 0) begin
      other_errs++;
      $display("trace holds no instructions");
    end
    // worst case fetch plus stall per line, with margin
    limit = n_lines * 12 + 100;
    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;
    if (other_errs != 0) begin
      end_run();
    end
  end

  ////////////////////////////////////////
  // per-cycle checks and stimulus
  ////////////////////////////////////////
  always @(posedge clk_i) begin
    if (!rst_i) begin
      cycles++;
      if (first_chk) begin
        first_chk = 1'b0;
        if (wb_cyc || dec_valid) begin
          proto_errs++;
          $display("bus cycle or valid already high in the first cycle after reset");
        end
      end
      // wishbone rules
      if (wb_stb && !wb_cyc) begin
        proto_errs++;
        $display("stb high without cyc");
      end
      if (wb_we) begin
        proto_errs++;
        $display("write enable raised on a read-only master");
      end
      if (prev_cyc && !prev_ack && wb_cyc) begin
        check_val("wb_adr_o", 64'(wb_adr), 64'(prev_adr));
      end
      if (dec_valid && wb_cyc) begin
        proto_errs++;
        $display("bus cycle open while an instruction is held");
      end
      // back-pressure, everything frozen
      if (prev_valid && !prev_ready) begin
        if (!dec_valid) begin
          proto_errs++;
          $display("valid dropped without a transfer");
        end
        check_val("dec_pc_o", 64'(dec_pc), 64'(prev_pc));
        check_val("dec_func_o", 64'(dec_func), 64'(prev_func));
        check_val("dec_rd_o", 64'(dec_rd), 64'(prev_rd));
        check_val("dec_rs1_o", 64'(dec_rs1), 64'(prev_rs1));
        check_val("dec_rs2_o", 64'(dec_rs2), 64'(prev_rs2));
        check_val("dec_imm_o", dec_imm, prev_imm);
      end
      // accepted transfer against the trace
      if (dec_valid && dec_ready) begin
        check_val("dec_pc_o", 64'(dec_pc), 64'(n_xfer * 4));
        check_val("dec_func_o", 64'(dec_func), 64'(exp_func[n_xfer]));
        check_val("dec_rd_o", 64'(dec_rd), 64'(exp_rd[n_xfer]));
        check_val("dec_rs1_o", 64'(dec_rs1), 64'(exp_rs1[n_xfer]));
        check_val("dec_rs2_o", 64'(dec_rs2), 64'(exp_rs2[n_xfer]));
        check_val("dec_imm_o", dec_imm, exp_imm[n_xfer]);
        n_xfer++;
        if (n_xfer == n_entries) begin
          done = 1'b1;
        end
      end
      if (!done && cycles >= limit) begin
        other_errs++;
        $display("timeout after %0d cycles, %0d of %0d instructions accepted",
                 cycles, n_xfer, n_entries);
        done = 1'b1;
      end
      prev_valid = dec_valid;
      prev_ready = dec_ready;
      prev_cyc   = wb_cyc;
      prev_ack   = wb_ack;
      prev_adr   = wb_adr;
      prev_pc    = dec_pc;
      prev_func  = dec_func;
      prev_rd    = dec_rd;
      prev_rs1   = dec_rs1;
      prev_rs2   = dec_rs2;
      prev_imm   = dec_imm;
    end
    // one bit for ready, two for the wait count
    lfsr = lfsr_next(lfsr);
    dec_ready <= rst_i ? 1'b0 : lfsr[0];
    lfsr = lfsr_next(lfsr);
    wait_bits[0] <= lfsr[0];
    lfsr = lfsr_next(lfsr);
    wait_bits[1] <= lfsr[0];
    if (done) begin
      end_run();
    end
  end

endmodule

`default_nettype wire

/* rv_frontend_trace.txt */
// instr    func rd rs1 rs2 imm (64 bit), all hex
// last line all zero ends the trace
00410083 01 01 02 00 0000000000000004
fff11083 02 01 02 00 ffffffffffffffff
7ff12083 03 01 02 00 00000000000007ff
80013083 04 01 02 00 fffffffffffff800
01014083 05 01 02 00 0000000000000010
02015083 06 01 02 00 0000000000000020
00016083 07 01 02 00 0000000000000000
00310423 08 00 02 03 0000000000000008
fe311e23 09 00 02 03 fffffffffffffffc
7e312fa3 0a 00 02 03 00000000000007ff
10313023 0b 00 02 03 0000000000000100
00310463 0c 00 02 03 0000000000000008
fe311ce3 0d 00 02 03 fffffffffffffff8
00314863 0e 00 02 03 0000000000000010
7e315fe3 0f 00 02 03 0000000000000ffe
80316063 10 00 02 03 fffffffffffff000
02317063 11 00 02 03 0000000000000020
008000ef 12 01 00 00 0000000000000008
fffff0ef 12 01 00 00 fffffffffffffffe
7ffff0ef 12 01 00 00 00000000000ffffe
00c100e7 13 01 02 00 000000000000000c
123450b7 14 01 00 00 0000000012345000
fffff0b7 14 01 00 00 fffffffffffff000
80000097 15 01 00 00 ffffffff80000000
fff10093 16 01 02 00 ffffffffffffffff
00512093 17 01 02 00 0000000000000005
00713093 18 01 02 00 0000000000000007
0ff14093 19 01 02 00 00000000000000ff
80016093 1a 01 02 00 fffffffffffff800
7ff17093 1b 01 02 00 00000000000007ff
00311093 1c 01 02 00 0000000000000003
02115093 1d 01 02 00 0000000000000021
40415093 1e 01 02 00 0000000000000404
003100b3 1f 01 02 03 0000000000000000
403100b3 20 01 02 03 0000000000000000
003110b3 21 01 02 03 0000000000000000
003120b3 22 01 02 03 0000000000000000
003130b3 23 01 02 03 0000000000000000
003140b3 24 01 02 03 0000000000000000
003150b3 25 01 02 03 0000000000000000
403150b3 26 01 02 03 0000000000000000
003160b3 27 01 02 03 0000000000000000
003170b3 28 01 02 03 0000000000000000
ff81009b 29 01 02 00 fffffffffffffff8
0051109b 2a 01 02 00 0000000000000005
01f1509b 2b 01 02 00 000000000000001f
4011509b 2c 01 02 00 0000000000000401
003100bb 2d 01 02 03 0000000000000000
403100bb 2e 01 02 03 0000000000000000
003110bb 2f 01 02 03 0000000000000000
003150bb 30 01 02 03 0000000000000000
403150bb 31 01 02 03 0000000000000000
0ff0000f 32 00 00 00 00000000000000ff
00000073 33 00 00 00 0000000000000000
00100073 34 00 00 00 0000000000000000
30011073 00 00 00 00 0000000000000000
ffffffff 00 00 00 00 0000000000000000
40011093 00 00 00 00 0000000000000000
023100b3 00 00 00 00 0000000000000000
00017083 00 00 00 00 0000000000000000
00c110e7 00 00 00 00 0000000000000000
00312063 00 00 00 00 0000000000000000
00000000 00 00 00 00 0000000000000000

/* filelist.f */
riscv_pkg.sv
rv_if.sv
rv_imm_gen.sv
rv_id.sv
rv_frontend.sv
rv_frontend_tb_mem.sv
rv_frontend_tb.sv

/* Makefile */
# Verilator build and run of the front end testbench

TB  := rv_frontend_tb
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -sv -f filelist.f --top-module $(TB) \
		--Mdir obj_dir -o $(TB)

run: build
	./obj_dir/$(TB) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST PASSED" $(LOG)

lint:
	verilator --lint-only --timing --assert -sv riscv_pkg.sv rv_if.sv rv_imm_gen.sv \
		rv_id.sv rv_frontend.sv --top-module rv_frontend

clean:
	rm -rf obj_dir $(LOG)
